/* mskPkg.sv */
`default_nettype none

package mskPkg;

	//////////////////////////////////////////////////
	// Word and sample widths
	//////////////////////////////////////////////////

	// FIFO word width in bits
	localparam int NIBBLE_W = 4;

	// Signed I and Q sample width
	localparam int SAMPLE_W = 4;

	//////////////////////////////////////////////////
	// Constellation
	//////////////////////////////////////////////////

	// Magnitude on each axis
	// Negated for quadrants left of or below the origin
	localparam logic signed [SAMPLE_W-1:0] AMPLITUDE = SAMPLE_W'(5);

	// Modulator FSM states
	typedef enum logic {
		MOD_IDLE,
		MOD_SEND
	} modState_t;

endpackage

`default_nettype wire

/* inFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module inFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input wire								inClock,
	input wire								i_rstN,
	// Nibble write side
	input wire								i_wrEn,
	input wire [mskPkg::NIBBLE_W-1:0]		i_wrData,
	output logic							o_full,
	// Serial read side
	input wire								i_readEn,
	output logic							o_bit,
	output logic							o_empty
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = ADDR_W + 1;

	// Circular nibble buffer
	logic [mskPkg::NIBBLE_W-1:0] mem [FIFO_DEPTH];
	logic [ADDR_W-1:0] wrPtr;
	logic [ADDR_W-1:0] rdPtr;
	// Nibbles not yet fully sent
	logic [CNT_W-1:0] count;
	// Bit position inside head nibble
	logic [1:0] bitIdx;
	logic wrDo;
	logic rdDo;
	logic popDo;

	// Write dropped when full, read ignored when empty
	assign wrDo = i_wrEn && !o_full;
	assign rdDo = i_readEn && !o_empty;
	// Head nibble retires on its last bit
	assign popDo = rdDo && (bitIdx == 2'(mskPkg::NIBBLE_W - 1));

	assign o_full = (count == CNT_W'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	// Current head bit, MSB first
	assign o_bit = mem[rdPtr][2'(mskPkg::NIBBLE_W - 1) - bitIdx];

	// Storage write
	always_ff @(posedge inClock) begin
		if (wrDo)
			mem[wrPtr] <= i_wrData;
	end

	//////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////
	always_ff @(posedge inClock or negedge i_rstN) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			bitIdx <= 2'd0;
		end else begin
			if (wrDo)
				wrPtr <= wrPtr + 1'b1;
			// Step through head bits, wrap on pop
			if (rdDo)
				bitIdx <= bitIdx + 1'b1;
			if (popDo)
				rdPtr <= rdPtr + 1'b1;
			case ({wrDo, popDo})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mskModulator.sv */
`timescale 1ns/1ps
`default_nettype none

module mskModulator #(
	parameter int SYMBOL_SAMPLES = 4
) (
	input wire										inClock,
	input wire										i_rstN,
	// Bit source
	input wire										i_bit,
	input wire										i_empty,
	output logic									o_readEn,
	// Baseband samples
	output logic signed [mskPkg::SAMPLE_W-1:0]		o_sinI,
	output logic signed [mskPkg::SAMPLE_W-1:0]		o_sinQ,
	output logic									o_sampleValid
);

	localparam int CNT_W = $clog2(SYMBOL_SAMPLES);

	mskPkg::modState_t state;
	// Sample index within the symbol
	logic [CNT_W-1:0] sampleCnt;
	// Carrier phase as quadrant
	logic [1:0] quadrant;
	logic lastSample;
	logic iNeg;
	logic qNeg;

	assign lastSample = (sampleCnt == CNT_W'(SYMBOL_SAMPLES - 1));

	// Pop on start or at symbol end for back to back symbols
	assign o_readEn = !i_empty && ((state == mskPkg::MOD_IDLE) || lastSample);
	assign o_sampleValid = (state == mskPkg::MOD_SEND);

	//////////////////////////////////////////////////
	// Quadrant to I/Q point
	//////////////////////////////////////////////////
	// I negative in quadrants 1 and 2
	assign iNeg = quadrant[1] ^ quadrant[0];
	// Q negative in quadrants 2 and 3
	assign qNeg = quadrant[1];
	assign o_sinI = iNeg ? -mskPkg::AMPLITUDE : mskPkg::AMPLITUDE;
	assign o_sinQ = qNeg ? -mskPkg::AMPLITUDE : mskPkg::AMPLITUDE;

	//////////////////////////////////////////////////
	// Symbol FSM
	//////////////////////////////////////////////////
	always_ff @(posedge inClock or negedge i_rstN) begin
		if (!i_rstN) begin
			state <= mskPkg::MOD_IDLE;
			sampleCnt <= '0;
			quadrant <= 2'd0;
		end else begin
			// Bit 1 turns counterclockwise, bit 0 clockwise
			if (o_readEn)
				quadrant <= i_bit ? quadrant + 2'd1 : quadrant - 2'd1;
			case (state)
				mskPkg::MOD_IDLE: begin
					sampleCnt <= '0;
					if (!i_empty)
						state <= mskPkg::MOD_SEND;
				end
				mskPkg::MOD_SEND: begin
					if (lastSample) begin
						sampleCnt <= '0;
						// Nothing queued so wait
						if (i_empty)
							state <= mskPkg::MOD_IDLE;
					end else begin
						sampleCnt <= sampleCnt + 1'b1;
					end
				end
				default: state <= mskPkg::MOD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* phaseDirection.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseDirection (
	input wire										inClock,
	input wire										i_rstN,
	// Received samples
	input wire										i_sampleValid,
	input wire signed [mskPkg::SAMPLE_W-1:0]		i_sinI,
	input wire signed [mskPkg::SAMPLE_W-1:0]		i_sinQ,
	// Recovered bits
	output logic									o_bit,
	output logic									o_bitValid
);

	// Quadrant of incoming sample
	logic [1:0] sampleQuad;
	// Quadrant of previous strobe
	logic [1:0] refQuad;
	// Signed step modulo 4
	logic [1:0] quadStep;
	logic stepUp;
	logic stepDown;

	// Sign bits give the quadrant, zero counts positive
	assign sampleQuad = {i_sinQ[mskPkg::SAMPLE_W-1],
		i_sinQ[mskPkg::SAMPLE_W-1] ^ i_sinI[mskPkg::SAMPLE_W-1]};

	assign quadStep = sampleQuad - refQuad;
	// One step up is bit 1
	assign stepUp = (quadStep == 2'd1);
	// One step down is bit 0
	assign stepDown = (quadStep == 2'd3);

	//////////////////////////////////////////////////
	// Reference tracking and bit strobe
	//////////////////////////////////////////////////
	always_ff @(posedge inClock or negedge i_rstN) begin
		if (!i_rstN) begin
			refQuad <= 2'd0;
			o_bitValid <= 1'b0;
		end else begin
			// Jumps of two still move the reference
			if (i_sampleValid)
				refQuad <= sampleQuad;
			o_bitValid <= i_sampleValid && (stepUp || stepDown);
		end
	end

	// Bit value beside the strobe
	always_ff @(posedge inClock) begin
		if (i_sampleValid)
			o_bit <= stepUp;
	end

endmodule

`default_nettype wire

/* outFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module outFifo #(
	parameter int FIFO_DEPTH = 8
) (
	input wire								inClock,
	input wire								i_rstN,
	// Serial bit input
	input wire								i_bit,
	input wire								i_bitValid,
	// Fall-through read side
	input wire								i_rdEn,
	output logic [mskPkg::NIBBLE_W-1:0]		o_rdData,
	output logic							o_empty
);

	localparam int ADDR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = ADDR_W + 1;

	// Bit assembly
	logic [mskPkg::NIBBLE_W-1:0] shiftReg;
	logic [1:0] bitCnt;
	logic [mskPkg::NIBBLE_W-1:0] pushWord;
	// Nibble buffer
	logic [mskPkg::NIBBLE_W-1:0] mem [FIFO_DEPTH];
	logic [ADDR_W-1:0] wrPtr;
	logic [ADDR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic full;
	logic pushDo;
	logic popDo;

	// Completed nibble including current bit
	assign pushWord = {shiftReg[mskPkg::NIBBLE_W-2:0], i_bit};
	assign full = (count == CNT_W'(FIFO_DEPTH));
	// Fourth bit pushes unless full
	assign pushDo = i_bitValid && (bitCnt == 2'(mskPkg::NIBBLE_W - 1)) && !full;
	assign popDo = i_rdEn && !o_empty;

	assign o_empty = (count == '0);
	// Head nibble shown directly
	assign o_rdData = mem[rdPtr];

	//////////////////////////////////////////////////
	// Shift register and storage
	//////////////////////////////////////////////////
	always_ff @(posedge inClock) begin
		if (i_bitValid)
			shiftReg <= pushWord;
		if (pushDo)
			mem[wrPtr] <= pushWord;
	end

	// Control state
	always_ff @(posedge inClock or negedge i_rstN) begin
		if (!i_rstN) begin
			bitCnt <= 2'd0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (i_bitValid)
				bitCnt <= bitCnt + 1'b1;
			if (pushDo)
				wrPtr <= wrPtr + 1'b1;
			if (popDo)
				rdPtr <= rdPtr + 1'b1;
			case ({pushDo, popDo})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* mskModemTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mskModemTop #(
	parameter int SYMBOL_SAMPLES = 4,
	parameter int FIFO_DEPTH = 8
) (
	input wire										inClock,
	input wire										i_rstN,
	// Transmit nibbles
	input wire										i_wrEn,
	input wire [mskPkg::NIBBLE_W-1:0]				i_wrData,
	output logic									o_full,
	// Receiver source select and ADC port
	input wire										i_loopback,
	input wire										i_adcEoc,
	input wire signed [mskPkg::SAMPLE_W-1:0]		i_adcI,
	input wire signed [mskPkg::SAMPLE_W-1:0]		i_adcQ,
	// Transmit samples
	output logic signed [mskPkg::SAMPLE_W-1:0]		o_txI,
	output logic signed [mskPkg::SAMPLE_W-1:0]		o_txQ,
	output logic									o_txValid,
	// Received nibbles
	input wire										i_rdEn,
	output logic [mskPkg::NIBBLE_W-1:0]				o_rdData,
	output logic									o_empty
);

	//////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////
	logic txBit;
	logic txEmpty;
	logic txReadEn;
	logic signed [mskPkg::SAMPLE_W-1:0] rxI;
	logic signed [mskPkg::SAMPLE_W-1:0] rxQ;
	logic rxStrobe;
	logic rxBit;
	logic rxBitValid;

	// Input FIFO, serial out
	inFifo #(
		.FIFO_DEPTH		(FIFO_DEPTH		)
	) u_inFifo (
		.inClock		(inClock		),
		.i_rstN			(i_rstN			),
		.i_wrEn			(i_wrEn			),
		.i_wrData		(i_wrData		),
		.o_full			(o_full			),
		.i_readEn		(txReadEn		),
		.o_bit			(txBit			),
		.o_empty		(txEmpty		)
	);

	// Coder
	mskModulator #(
		.SYMBOL_SAMPLES	(SYMBOL_SAMPLES	)
	) u_coder (
		.inClock		(inClock		),
		.i_rstN			(i_rstN			),
		.i_bit			(txBit			),
		.i_empty		(txEmpty		),
		.o_readEn		(txReadEn		),
		.o_sinI			(o_txI			),
		.o_sinQ			(o_txQ			),
		.o_sampleValid	(o_txValid		)
	);

	// Loopback mux in front of the receiver
	assign rxI = i_loopback ? o_txI : i_adcI;
	assign rxQ = i_loopback ? o_txQ : i_adcQ;
	assign rxStrobe = i_loopback ? o_txValid : i_adcEoc;

	// Phase direction detector
	phaseDirection u_phaseDir (
		.inClock		(inClock		),
		.i_rstN			(i_rstN			),
		.i_sampleValid	(rxStrobe		),
		.i_sinI			(rxI			),
		.i_sinQ			(rxQ			),
		.o_bit			(rxBit			),
		.o_bitValid		(rxBitValid		)
	);

	// Output FIFO, nibble out
	outFifo #(
		.FIFO_DEPTH		(FIFO_DEPTH		)
	) u_outFifo (
		.inClock		(inClock		),
		.i_rstN			(i_rstN			),
		.i_bit			(rxBit			),
		.i_bitValid		(rxBitValid		),
		.i_rdEn			(i_rdEn			),
		.o_rdData		(o_rdData		),
		.o_empty		(o_empty		)
	);

endmodule

`default_nettype wire

/* mskModemTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mskModemTb;

	localparam int SYMBOL_SAMPLES = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int NW = mskPkg::NIBBLE_W;
	localparam int SW = mskPkg::SAMPLE_W;
	localparam int LOOP_NIBBLES = 40;
	localparam int ADC_POINTS = 48;
	// Every bit of the run with the ADC padding
	localparam int BITS_SENT = (LOOP_NIBBLES + FIFO_DEPTH) * NW + ADC_POINTS + NW - 1;
	localparam int CYCLE_LIMIT = 20 * BITS_SENT + 500;
	// Largest positive ADC coordinate
	localparam int MAX_POS = 2 ** (SW - 1) - 1;
	localparam logic signed [SW-1:0] TX_AMP = SW'(5);

	logic inClock;
	logic i_rstN;
	logic i_wrEn;
	logic [NW-1:0] i_wrData;
	logic o_full;
	logic i_loopback;
	logic i_adcEoc;
	logic signed [SW-1:0] i_adcI;
	logic signed [SW-1:0] i_adcQ;
	logic signed [SW-1:0] o_txI;
	logic signed [SW-1:0] o_txQ;
	logic o_txValid;
	logic i_rdEn;
	logic [NW-1:0] o_rdData;
	logic o_empty;

	// Reference model state
	logic [1:0] txModelQuad;
	logic [1:0] rxRefQuad;
	logic [NW-1:0] adcNibble;
	int adcBits;
	logic [NW-1:0] expNibbles [$];
	logic [1:0] expQuads [$];

	mskModemTop #(
		.SYMBOL_SAMPLES	(SYMBOL_SAMPLES	),
		.FIFO_DEPTH		(FIFO_DEPTH		)
	) UUT (
		.inClock		(inClock		),
		.i_rstN			(i_rstN			),
		.i_wrEn			(i_wrEn			),
		.i_wrData		(i_wrData		),
		.o_full			(o_full			),
		.i_loopback		(i_loopback		),
		.i_adcEoc		(i_adcEoc		),
		.i_adcI			(i_adcI			),
		.i_adcQ			(i_adcQ			),
		.o_txI			(o_txI			),
		.o_txQ			(o_txQ			),
		.o_txValid		(o_txValid		),
		.i_rdEn			(i_rdEn			),
		.o_rdData		(o_rdData		),
		.o_empty		(o_empty		)
	);

	initial begin
		inClock = 1'b0;
		forever #5 inClock = ~inClock;
	end

	//////////////////////////////////////////////////
	// Reference model and helpers
	//////////////////////////////////////////////////

	// Bit 1 steps counterclockwise, bit 0 clockwise
	function automatic logic [1:0] nextQuadrant(input logic [1:0] quad, input logic bitVal);
		return bitVal ? quad + 2'd1 : quad - 2'd1;
	endfunction

	// Random coordinate with the wanted sign
	// Zero counts as positive
	function automatic logic signed [SW-1:0] adcAxis(input logic negative);
		int mag;
		if (negative) begin
			mag = $urandom_range(MAX_POS + 1, 1);
			return -SW'(mag);
		end
		mag = $urandom_range(MAX_POS, 0);
		return SW'(mag);
	endfunction

	task automatic endWithFailure();
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped on first error");
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		assert (actual === expected) else begin
			$display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
			endWithFailure();
		end
	endtask

	// Inputs change 1 ns after the edge
	task automatic stepCycle();
		@(posedge inClock);
		#1;
	endtask

	task automatic sendNibble(input logic [NW-1:0] value);
		i_wrEn = 1'b1;
		i_wrData = value;
		expNibbles.push_back(value);
		// One symbol per bit in MSB first order
		for (int b = NW - 1; b >= 0; b--) begin
			txModelQuad = nextQuadrant(txModelQuad, value[b]);
			expQuads.push_back(txModelQuad);
		end
		stepCycle();
		i_wrEn = 1'b0;
	endtask

	// One ADC strobe plus the bit it should give
	task automatic strobeAdcPoint(input logic [1:0] quad);
		logic stepUp;
		logic stepDown;
		stepUp = (quad == nextQuadrant(rxRefQuad, 1'b1));
		stepDown = (quad == nextQuadrant(rxRefQuad, 1'b0));
		if (stepUp || stepDown) begin
			adcNibble = {adcNibble[NW-2:0], stepUp};
			adcBits++;
			if (adcBits % NW == 0)
				expNibbles.push_back(adcNibble);
		end
		// Repeats and jumps of two still move the reference
		rxRefQuad = quad;
		i_adcI = adcAxis(quad == 2'd1 || quad == 2'd2);
		i_adcQ = adcAxis(quad == 2'd2 || quad == 2'd3);
		i_adcEoc = 1'b1;
		stepCycle();
		i_adcEoc = 1'b0;
		repeat ($urandom_range(2, 0)) stepCycle();
	endtask

	// Until every sent nibble is back and the coder is quiet
	task automatic waitDrained();
		while (expNibbles.size() != 0 || o_txValid)
			stepCycle();
		repeat (2) stepCycle();
	endtask

	//////////////////////////////////////////////////
	// Output compare popping while not empty
	//////////////////////////////////////////////////
	initial begin : compareOutput
		i_rdEn = 1'b0;
		forever begin
			stepCycle();
			i_rdEn = 1'b0;
			if (!o_empty) begin
				assert (expNibbles.size() != 0) else begin
					$display("Output FIFO returned a nibble that was never sent");
					endWithFailure();
				end
				assert (o_rdData === expNibbles[0]) else begin
					$display("Error: o_rdData = 0x%h, expected 0x%h", o_rdData, expNibbles[0]);
					endWithFailure();
				end
				void'(expNibbles.pop_front());
				i_rdEn = 1'b1;
			end
		end
	end

	// Transmit sample monitor
	initial begin : checkTxSamples
		int runLen;
		logic [1:0] quad;
		logic signed [SW-1:0] expI;
		logic signed [SW-1:0] expQ;
		runLen = 0;
		expI = '0;
		expQ = '0;
		forever begin
			stepCycle();
			if (o_txValid) begin
				// New symbol every SYMBOL_SAMPLES valid cycles
				if (runLen == 0 || runLen == SYMBOL_SAMPLES) begin
					assert (expQuads.size() != 0) else begin
						$display("Transmit samples appeared with no bit queued");
						endWithFailure();
					end
					quad = expQuads.pop_front();
					expI = (quad == 2'd1 || quad == 2'd2) ? -TX_AMP : TX_AMP;
					expQ = (quad == 2'd2 || quad == 2'd3) ? -TX_AMP : TX_AMP;
					runLen = 0;
				end
				assert (o_txI === expI) else begin
					$display("Error: o_txI = 0x%h, expected 0x%h", o_txI, expI);
					endWithFailure();
				end
				assert (o_txQ === expQ) else begin
					$display("Error: o_txQ = 0x%h, expected 0x%h", o_txQ, expQ);
					endWithFailure();
				end
				runLen++;
			end else begin
				assert (runLen == 0 || runLen == SYMBOL_SAMPLES) else begin
					$display("Transmit run stopped after %0d of %0d samples",
						runLen, SYMBOL_SAMPLES);
					endWithFailure();
				end
				runLen = 0;
			end
		end
	end

	// Cycle limit
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge inClock);
			cycles++;
		end
		$display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
		endWithFailure();
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin : mainSequence
		void'($urandom(32'h153a9f42));
		i_rstN = 1'b0;
		i_wrEn = 1'b0;
		i_wrData = '0;
		i_loopback = 1'b1;
		i_adcEoc = 1'b0;
		i_adcI = '0;
		i_adcQ = '0;
		txModelQuad = 2'd0;
		rxRefQuad = 2'd0;
		adcNibble = '0;
		adcBits = 0;
		repeat (16) @(posedge inClock);
		#1;
		i_rstN = 1'b1;

		// Idle flags after reset
		checkFlag("o_txValid", o_txValid, 1'b0);
		checkFlag("o_empty", o_empty, 1'b1);
		checkFlag("o_full", o_full, 1'b0);

		// Loopback with random gaps
		for (int n = 0; n < LOOP_NIBBLES; n++) begin
			repeat ($urandom_range(7, 0)) stepCycle();
			while (o_full)
				stepCycle();
			sendNibble(NW'($urandom_range(15, 0)));
		end
		waitDrained();

		// Back to back writes fill the input FIFO
		for (int n = 0; n < FIFO_DEPTH; n++)
			sendNibble(NW'($urandom_range(15, 0)));
		checkFlag("o_full", o_full, 1'b1);
		waitDrained();

		// External ADC
		// Detector still holds the last coder quadrant
		i_loopback = 1'b0;
		rxRefQuad = txModelQuad;
		strobeAdcPoint(rxRefQuad);
		strobeAdcPoint(rxRefQuad + 2'd2);
		for (int n = 2; n < ADC_POINTS; n++)
			strobeAdcPoint(rxRefQuad + 2'($urandom_range(3, 0)));
		// Pad to whole nibbles
		while (adcBits % NW != 0)
			strobeAdcPoint(nextQuadrant(rxRefQuad, 1'b1));
		waitDrained();

		checkFlag("o_empty", o_empty, 1'b1);
		assert (expQuads.size() == 0) else begin
			$display("%0d transmit symbols never appeared", expQuads.size());
			endWithFailure();
		end
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
mskPkg.sv
inFifo.sv
mskModulator.sv
phaseDirection.sv
outFifo.sv
mskModemTop.sv
mskModemTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mskModemTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
